// ==== vlog.f ====
+incdir+include
logic/hist_pkg.sv
logic/hist_sequencer.sv
logic/hist_accumulator.sv
logic/hist_readout.sv
logic/hist_top.sv
verif/hist_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the histogram testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal \
    -f vlog.f --top-module hist_tb -o hist_tb_sim > build.log 2>&1 \
    && ./obj_dir/hist_tb_sim > sim.log 2>&1 \
    || { echo "build or simulation run broke, see build.log and sim.log"; exit 1; }

cat sim.log

# result decided by the pass line in the log
grep -qx -- '>>> PASS' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== include/hist_tb_util.svh ====
`ifndef HIST_TB_UTIL_SVH
`define HIST_TB_UTIL_SVH

// lfsr seed for stimulus
localparam logic [15:0] LFSR_SEED = 16'd47;

// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
endfunction

// take nbits random bits, one lfsr step per bit
task automatic lfsr_take(ref logic [15:0] state, input int nbits, output int value);
    value = 0;
    for (int i = 0; i < nbits; i++) begin
        state = lfsr_next(state);
        value = (value << 1) | state[0];
    end
endtask

// compare one value, report and count a mismatch
task automatic check_value(input string name, input int expected, input int seen,
                           ref int checks, ref int fails);
    checks++;
    assert (seen == expected)
    else begin
        $display("FAIL t=%0t %s expected %0d seen %0d", $time, name, expected, seen);
        fails++;
    end
endtask

`endif

// ==== verif/hist_tb.sv ====
`timescale 1ns/100ps

module hist_tb
    import hist_pkg::*;
();

`include "hist_tb_util.svh"

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    localparam int FRAME_HITS = HITS_PER_PIXEL * NUM_PIXELS * NUM_ACQ;
    // frames driven in all tests
    // the cut frame before the mid-run reset counts as one
    localparam int TOTAL_FRAMES = 9;
    // each hit takes at most 4 cycles plus readout slack per frame
    localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * (FRAME_HITS * 4 + 40) + 3 * RESET_CYCLES;

    logic      clk;
    logic      res;
    logic      hit_valid;
    bin_addr_t hit_bin;
    logic      his_num;
    logic      frame_done;
    logic      rd_valid;
    pixel_t    rd_pixel;
    bin_addr_t rd_bin;
    count_t    rd_count;

    logic [15:0] lfsr;
    int          n_checks;
    int          n_fails;

    // histogram model with its own counter chain
    int model_tab [NUM_PIXELS][NUM_BINS];
    int m_hit;
    int m_pix;
    int m_acq;
    // finished frames as pixel-major words
    int exp_q [$];

    // monitor state
    int   cyc;
    int   fd_cyc;
    int   fd_count;
    int   hits_since;
    // expected bank select, starts at 0 and flips on every frame pulse
    logic bank_exp;
    int   rd_idx;
    int   readouts;
    int   rd_words [FRAME_WORDS];

    hist_top dut0 (
        .clk        (clk),
        .res        (res),
        .hit_valid  (hit_valid),
        .hit_bin    (hit_bin),
        .his_num    (his_num),
        .frame_done (frame_done),
        .rd_valid   (rd_valid),
        .rd_pixel   (rd_pixel),
        .rd_bin     (rd_bin),
        .rd_count   (rd_count)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // one hit into the model with saturating counts
    task automatic count_model_hit(input int bin);
        if (model_tab[m_pix][bin - 1] < COUNT_MAX) begin
            model_tab[m_pix][bin - 1]++;
        end
        m_hit++;
        if (m_hit == HITS_PER_PIXEL) begin
            m_hit = 0;
            m_pix++;
            if (m_pix == NUM_PIXELS) begin
                m_pix = 0;
                m_acq++;
                if (m_acq == NUM_ACQ) begin
                    m_acq = 0;
                    // snapshot the closed frame then start empty
                    for (int p = 0; p < NUM_PIXELS; p++) begin
                        for (int b = 0; b < NUM_BINS; b++) begin
                            exp_q.push_back(model_tab[p][b]);
                            model_tab[p][b] = 0;
                        end
                    end
                end
            end
        end
    endtask

    task automatic clear_model();
        for (int p = 0; p < NUM_PIXELS; p++) begin
            for (int b = 0; b < NUM_BINS; b++) begin
                model_tab[p][b] = 0;
            end
        end
        m_hit = 0;
        m_pix = 0;
        m_acq = 0;
        exp_q.delete();
    endtask

    // hit strobe followed by gap idle cycles
    task automatic send_hit(input int bin, input int gap);
        @(posedge clk);
        hit_valid <= 1'b1;
        hit_bin   <= bin_addr_t'(bin);
        count_model_hit(bin);
        repeat (gap) begin
            @(posedge clk);
            hit_valid <= 1'b0;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            hit_valid <= 1'b0;
        end
    endtask

    // bin is 3 bits plus one and gap is 2 bits
    task automatic random_hits(input int n);
        int bin;
        int gap;
        for (int i = 0; i < n; i++) begin
            lfsr_take(lfsr, 3, bin);
            lfsr_take(lfsr, 2, gap);
            send_hit(bin + 1, gap);
        end
    endtask

    task automatic wait_readout(input int target);
        int n;
        n = 0;
        while (readouts < target && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (readouts < target) begin
            $display("error t=%0t readout %0d never completed", $time, target);
            n_fails++;
        end
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("test %s finished with %0d errors", name, n_fails - fails_before);
    endtask

    // outputs sampled mid-cycle away from the edges
    always @(negedge clk) begin : monitor
        int exp_word;
        cyc++;
        if (!res) begin
            hits_since = 0;
            bank_exp   = 1'b0;
            rd_idx     = 0;
        end else begin
            // bank select moves only with the frame pulse
            if (frame_done) begin
                bank_exp = ~bank_exp;
                check_value("hits per frame", FRAME_HITS, hits_since, n_checks, n_fails);
                hits_since = 0;
                fd_count++;
                fd_cyc = cyc;
            end
            check_value("his_num", bank_exp, his_num, n_checks, n_fails);
            // accepted at the next edge
            if (hit_valid) begin
                hits_since++;
            end
            if (rd_valid) begin
                if (rd_idx == 0) begin
                    check_value("rd_valid delay", 3, cyc - fd_cyc, n_checks, n_fails);
                end
                if (rd_idx < FRAME_WORDS) begin
                    check_value("rd_pixel", rd_idx / NUM_BINS, rd_pixel, n_checks, n_fails);
                    check_value("rd_bin", rd_idx % NUM_BINS + 1, rd_bin, n_checks, n_fails);
                    if (exp_q.size() == 0) begin
                        $display("error t=%0t readout word with no frame expected", $time);
                        n_fails++;
                    end else begin
                        exp_word = exp_q.pop_front();
                        check_value("rd_count", exp_word, rd_count, n_checks, n_fails);
                    end
                    rd_words[rd_idx] = rd_count;
                end
                rd_idx++;
            end else if (rd_idx != 0) begin
                // end of a burst
                check_value("rd_valid length", FRAME_WORDS, rd_idx, n_checks, n_fails);
                rd_idx = 0;
                readouts++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run stopped after %0d cycles without finishing", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : stimulus
        int   fails_before;
        int   fd_before;
        int   bin;
        int   gap;
        logic his_before;
        clk       = 1'b0;
        res       = 1'b0;
        hit_valid = 1'b0;
        hit_bin   = bin_addr_t'(1);
        lfsr      = LFSR_SEED;
        n_checks  = 0;
        n_fails   = 0;
        cyc       = 0;
        fd_cyc    = 0;
        fd_count  = 0;
        readouts  = 0;
        clear_model();
        repeat (RESET_CYCLES) @(posedge clk);
        res <= 1'b1;

        // one frame of random bins and gaps
        fails_before = n_fails;
        random_hits(FRAME_HITS);
        idle_cycles(4);
        wait_readout(1);
        report_test("random_frame", fails_before);

        // pixel 0 back to back on bin 3
        // its 20 hits saturate the counter
        fails_before = n_fails;
        for (int i = 0; i < FRAME_HITS; i++) begin
            if (m_pix == 0) begin
                send_hit(3, 0);
            end else begin
                lfsr_take(lfsr, 3, bin);
                lfsr_take(lfsr, 2, gap);
                send_hit(bin + 1, gap);
            end
        end
        idle_cycles(4);
        wait_readout(2);
        check_value("rd_count p0 b3", COUNT_MAX, rd_words[2], n_checks, n_fails);
        report_test("forward_saturate", fails_before);

        // three frames in a row
        fails_before = n_fails;
        fd_before    = fd_count;
        his_before   = bank_exp;
        random_hits(3 * FRAME_HITS);
        idle_cycles(4);
        wait_readout(5);
        check_value("frame_done pulses", 3, fd_count - fd_before, n_checks, n_fails);
        his_before = ~his_before;
        check_value("his_num", his_before, his_num, n_checks, n_fails);
        report_test("frame_boundary", fails_before);

        // bank reuse shows any stale counts
        fails_before = n_fails;
        random_hits(2 * FRAME_HITS);
        idle_cycles(4);
        wait_readout(7);
        report_test("clear_on_read", fails_before);

        // cut a frame short with reset
        fails_before = n_fails;
        random_hits(37);
        idle_cycles(2);
        @(posedge clk);
        res       <= 1'b0;
        hit_valid <= 1'b0;
        clear_model();
        repeat (RESET_CYCLES) @(posedge clk);
        res <= 1'b1;
        @(negedge clk);
        check_value("his_num after reset", 0, his_num, n_checks, n_fails);
        fd_before = fd_count;
        random_hits(FRAME_HITS);
        idle_cycles(4);
        wait_readout(8);
        check_value("frame_done pulses", 1, fd_count - fd_before, n_checks, n_fails);
        report_test("reset_mid_frame", fails_before);

        $display("summary: %0d checks, %0d errors", n_checks, n_fails);
        if (n_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== logic/hist_top.sv ====
`timescale 1ns/100ps

module hist_top
    import hist_pkg::*;
(
    input  logic      clk,
    input  logic      res,
    input  logic      hit_valid,
    input  bin_addr_t hit_bin,
    output logic      his_num,
    output logic      frame_done,
    output logic      rd_valid,
    output pixel_t    rd_pixel,
    output bin_addr_t rd_bin,
    output count_t    rd_count
);

    // pixel of the hit presented this cycle
    pixel_t cur_pixel;

    // read-and-clear port, readout to accumulator
    logic       clr_en;
    word_addr_t clr_addr;
    count_t     clr_data;

    // hit, pixel and acquisition counting
    // owns frame_done and the bank select
    hist_sequencer u_sequencer (
        .clk        (clk),
        .res        (res),
        .hit_valid  (hit_valid),
        .cur_pixel  (cur_pixel),
        .his_num    (his_num),
        .frame_done (frame_done)
    );

    // two-bank histogram memory
    // accumulates into his_num, clears the other bank
    hist_accumulator u_accumulator (
        .clk       (clk),
        .res       (res),
        .hit_valid (hit_valid),
        .hit_bin   (hit_bin),
        .cur_pixel (cur_pixel),
        .his_num   (his_num),
        .clr_en    (clr_en),
        .clr_addr  (clr_addr),
        .clr_data  (clr_data)
    );

    // drains the finished bank after every frame
    // first word three cycles after frame_done
    hist_readout u_readout (
        .clk        (clk),
        .res        (res),
        .frame_done (frame_done),
        .clr_en     (clr_en),
        .clr_addr   (clr_addr),
        .clr_data   (clr_data),
        .rd_valid   (rd_valid),
        .rd_pixel   (rd_pixel),
        .rd_bin     (rd_bin),
        .rd_count   (rd_count)
    );

endmodule

// ==== logic/hist_readout.sv ====
`timescale 1ns/100ps

module hist_readout
    import hist_pkg::*;
(
    input  logic       clk,
    input  logic       res,
    input  logic       frame_done,
    output logic       clr_en,
    output word_addr_t clr_addr,
    input  count_t     clr_data,
    output logic       rd_valid,
    output pixel_t     rd_pixel,
    output bin_addr_t  rd_bin,
    output count_t     rd_count
);

    rd_state_t state;
    rd_state_t state_nxt;

    // word being cleared this cycle
    word_addr_t addr;
    // same word one cycle later, lines up with clr_data
    word_addr_t rd_word;

    // last word of the bank
    logic last_word;

    assign last_word = (addr == word_addr_t'(FRAME_WORDS - 1));

    // next state
    // frame_done cycle plus one drain cycle give the
    // last hit of the frame time to reach memory
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (frame_done) begin
                    state_nxt = DRAIN;
                end
            end
            DRAIN: begin
                state_nxt = STREAM;
            end
            STREAM: begin
                // 32 words, one per cycle
                if (last_word) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // state and word address
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state <= IDLE;
            addr  <= '0;
        end else begin
            state <= state_nxt;
            if (state == STREAM) begin
                addr <= addr + 1'b1;
            end else begin
                // start every readout at pixel 0 bin 1
                addr <= '0;
            end
        end
    end

    // read and clear one word per streaming cycle
    assign clr_en   = (state == STREAM);
    assign clr_addr = addr;

    // valid follows clr_en by the memory read latency
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= clr_en;
        end
    end

    // address delayed alongside the data
    always_ff @(posedge clk) begin
        rd_word <= addr;
    end

    // split word back into pixel and 1-based bin
    assign rd_pixel = pixel_t'(rd_word / NUM_BINS);
    assign rd_bin   = bin_addr_t'(rd_word % NUM_BINS + 1);
    // count straight from the clear port register
    assign rd_count = clr_data;

endmodule

// ==== logic/hist_accumulator.sv ====
`timescale 1ns/100ps

module hist_accumulator
    import hist_pkg::*;
(
    input  logic       clk,
    input  logic       res,
    input  logic       hit_valid,
    input  bin_addr_t  hit_bin,
    input  pixel_t     cur_pixel,
    input  logic       his_num,
    input  logic       clr_en,
    input  word_addr_t clr_addr,
    output count_t     clr_data
);

    // two banks back to back, bank bit on top of the word address
    count_t mem [2*FRAME_WORDS];

    // tdc bins start at 1
    bin_addr_t bin_m1;
    // word of the incoming hit inside its bank
    word_addr_t hit_word;
    // full memory addresses, bank bit included
    logic [$bits(word_addr_t):0] hit_mem_addr;
    logic [$bits(word_addr_t):0] clr_mem_addr;

    // stage 1, hit registered with the count read for it
    logic                        s1_valid;
    logic [$bits(word_addr_t):0] s1_addr;
    count_t                      s1_cnt;

    // stage 2 result, written at the next edge
    count_t s1_inc;
    // back-to-back hit on the word being written
    logic fwd;

    assign bin_m1 = hit_bin - 1'b1;

    // pixel-major word layout
    assign hit_word = word_addr_t'(cur_pixel * NUM_BINS + bin_m1);

    // hit goes to the bank selected by his_num
    assign hit_mem_addr = {his_num, hit_word};

    // clear port always works on the finished bank
    assign clr_mem_addr = {~his_num, clr_addr};

    // saturating increment
    // stays at COUNT_MAX once reached
    always_comb begin
        if (s1_cnt == count_t'(COUNT_MAX)) begin
            s1_inc = s1_cnt;
        end else begin
            s1_inc = s1_cnt + 1'b1;
        end
    end

    // memory still holds the old count while stage 2 writes,
    // so take the new count straight from the increment
    assign fwd = s1_valid && (s1_addr == hit_mem_addr);

    // stage 1 valid flag
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= hit_valid;
        end
    end

    // stage 1 payload and memory read
    always_ff @(posedge clk) begin
        if (hit_valid) begin
            // bank travels with the hit, a frame flip
            // does not move a hit already in flight
            s1_addr <= hit_mem_addr;
            if (fwd) begin
                s1_cnt <= s1_inc;
            end else begin
                s1_cnt <= mem[hit_mem_addr];
            end
        end
    end

    // read side of the clear port
    // data comes one cycle after clr_en
    always_ff @(posedge clk) begin
        if (clr_en) begin
            clr_data <= mem[clr_mem_addr];
        end
    end

    // memory write side
    // whole memory zeroed on reset, both banks read zero afterwards
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < 2*FRAME_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            // stage 2, write back the increment
            if (s1_valid) begin
                mem[s1_addr] <= s1_inc;
            end
            // clear on read
            // other bank, so no clash with the write above
            if (clr_en) begin
                mem[clr_mem_addr] <= '0;
            end
        end
    end

endmodule

// ==== logic/hist_sequencer.sv ====
`timescale 1ns/100ps

module hist_sequencer
    import hist_pkg::*;
(
    input  logic   clk,
    input  logic   res,
    input  logic   hit_valid,
    output pixel_t cur_pixel,
    output logic   his_num,
    output logic   frame_done
);

    // hits taken on the current pixel
    hit_cnt_t hit_cnt;
    // acquisitions finished in this frame
    acq_cnt_t acq_cnt;

    // wrap flags of the carry chain
    logic hit_wrap;
    logic pixel_wrap;
    logic acq_wrap;

    // last hit of the pixel
    assign hit_wrap = (hit_cnt == hit_cnt_t'(HITS_PER_PIXEL - 1));
    // last pixel of the acquisition
    assign pixel_wrap = (cur_pixel == pixel_t'(NUM_PIXELS - 1));
    // last acquisition of the frame
    assign acq_wrap = (acq_cnt == acq_cnt_t'(NUM_ACQ - 1));

    // nested counters as one carry chain
    // hit -> pixel -> acquisition -> frame
    // cur_pixel is the pixel register itself, so it is valid
    // for the hit presented in the same cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hit_cnt    <= '0;
            cur_pixel  <= '0;
            acq_cnt    <= '0;
            his_num    <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            // single-cycle pulse
            frame_done <= 1'b0;
            if (hit_valid) begin
                if (!hit_wrap) begin
                    hit_cnt <= hit_cnt + 1'b1;
                end else begin
                    // pixel done, carry into pixel counter
                    hit_cnt <= '0;
                    if (!pixel_wrap) begin
                        cur_pixel <= cur_pixel + 1'b1;
                    end else begin
                        // acquisition done
                        cur_pixel <= '0;
                        if (!acq_wrap) begin
                            acq_cnt <= acq_cnt + 1'b1;
                        end else begin
                            // frame closes on the 80th hit
                            // counters just restart from zero
                            acq_cnt    <= '0;
                            frame_done <= 1'b1;
                            // next hit lands in the other bank
                            his_num    <= ~his_num;
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== logic/hist_pkg.sv ====
package hist_pkg;

    // histogram geometry
    // time bins per pixel histogram
    localparam int NUM_BINS = 8;
    // pixels visited in one acquisition
    localparam int NUM_PIXELS = 4;
    // hits taken per pixel before stepping on
    localparam int HITS_PER_PIXEL = 4;
    // acquisitions per frame, 80 hits per frame in total
    localparam int NUM_ACQ = 5;

    // bin counter limit, counters hold here
    localparam int COUNT_MAX = 15;

    // words per bank, streamed out once per frame
    localparam int FRAME_WORDS = NUM_PIXELS * NUM_BINS;

    // hit bin address from the tdc, 1-based
    typedef logic [3:0] bin_addr_t;

    // pixel index
    typedef logic [1:0] pixel_t;

    // one bin count
    typedef logic [3:0] count_t;

    // word inside one bank
    // pixel-major, low bits are bin minus one
    typedef logic [4:0] word_addr_t;

    // hits seen on the current pixel
    typedef logic [1:0] hit_cnt_t;

    // acquisitions done in the current frame
    typedef logic [2:0] acq_cnt_t;

    // readout fsm states
    typedef enum logic [1:0] {
        IDLE,
        DRAIN,
        STREAM
    } rd_state_t;

endpackage
